/* flist.f */
lsq_pkg.sv
mem_pkg.sv
forward_select.sv
store_queue.sv
store_commit.sv
data_memory.sv
lsq_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_lsq.sv

/* tb_lsq.sv */
`timescale 1ns/10ps

module tb_lsq
	import lsq_pkg::*;
();

	logic    clock, reset;
	logic    dispatch_en, dispatch_addr_ready, dispatch_data_ready;
	addr_t   dispatch_addr, ex_addr, addr_rd;
	data_t   dispatch_data, ex_data, data_rd;
	logic    ex_en, ex_addr_en, ex_data_en, rt_en, rd_en;
	sq_idx_t ex_index, ld_pos, tail_out;
	logic    full, rd_valid, fwd_hit;
	int      chk_errors;
	logic    chk_empty;
	int      tb_errors;
	int      w;
	integer  seed = 32'h5f0f8d5c;

	// stores not yet retired, oldest first
	sq_idx_t p_tag [$];
	addr_t   p_addr [$];
	data_t   p_data [$];
	logic    p_ar [$];
	logic    p_dr [$];
	logic    disp_last; // dispatch at most every other cycle so full is seen in time

	tb_clock_gen u_clock_gen (.clock (clock), .reset (reset));

	lsq_top DUT (
		.clock (clock), .reset (reset),
		.dispatch_en (dispatch_en), .dispatch_addr (dispatch_addr),
		.dispatch_addr_ready (dispatch_addr_ready), .dispatch_data (dispatch_data),
		.dispatch_data_ready (dispatch_data_ready),
		.ex_en (ex_en), .ex_index (ex_index), .ex_addr (ex_addr),
		.ex_addr_en (ex_addr_en), .ex_data (ex_data), .ex_data_en (ex_data_en),
		.rt_en (rt_en), .rd_en (rd_en), .addr_rd (addr_rd), .ld_pos (ld_pos),
		.tail_out (tail_out), .full (full),
		.data_rd (data_rd), .rd_valid (rd_valid), .fwd_hit (fwd_hit)
	);

	tb_checker u_checker (
		.clock (clock), .reset (reset),
		.dispatch_en (dispatch_en), .dispatch_addr (dispatch_addr),
		.dispatch_addr_ready (dispatch_addr_ready), .dispatch_data (dispatch_data),
		.dispatch_data_ready (dispatch_data_ready),
		.ex_en (ex_en), .ex_index (ex_index), .ex_addr (ex_addr),
		.ex_addr_en (ex_addr_en), .ex_data (ex_data), .ex_data_en (ex_data_en),
		.rt_en (rt_en),
		.rd_en (rd_en), .addr_rd (addr_rd), .ld_pos (ld_pos),
		.tail_out (tail_out), .full (full),
		.data_rd (data_rd), .rd_valid (rd_valid), .fwd_hit (fwd_hit),
		.pop (DUT.pop), .mem_req (DUT.mem_req), // drain port is internal
		.mem_addr (DUT.mem_addr), .mem_wdata (DUT.mem_wdata),
		.errors (chk_errors), .empty (chk_empty)
	);

	// one clock of stimulus; mode 0 off, 1 random, 2 whenever allowed
	task drive_cycle(input int disp_mode, input int rt_mode);
		addr_t a;
		data_t d;
		logic  ar, dr, disp;
		int    j, pick, r;
		@(posedge clock);
		dispatch_en <= 1'b0;
		ex_en       <= 1'b0;
		ex_addr_en  <= 1'b0;
		ex_data_en  <= 1'b0;
		rt_en       <= 1'b0;
		rd_en       <= 1'b0;
		disp        = 1'b0;
		if (rt_mode != 0 && p_tag.size() > 0 && p_ar[0] && p_dr[0]
				&& (rt_mode == 2 || ($random(seed) & 1))) begin
			rt_en <= 1'b1; // in order, only once both halves are known
			void'(p_tag.pop_front());
			void'(p_addr.pop_front());
			void'(p_data.pop_front());
			void'(p_ar.pop_front());
			void'(p_dr.pop_front());
		end
		pick = -1;
		for (j = 0; j < p_tag.size(); j++)
			if (pick < 0 && !(p_ar[j] && p_dr[j]))
				pick = j;
		if (pick >= 0 && ($random(seed) & 1)) begin
			ex_en    <= 1'b1;
			ex_index <= p_tag[pick];
			if (!p_ar[pick]) begin // address first, data on a later cycle
				ex_addr_en  <= 1'b1;
				ex_addr     <= p_addr[pick];
				p_ar[pick]  = 1'b1;
			end else begin
				ex_data_en  <= 1'b1;
				ex_data     <= p_data[pick];
				p_dr[pick]  = 1'b1;
			end
		end
		if (disp_mode != 0 && !disp_last && !full
				&& (disp_mode == 2 || ($random(seed) & 3) != 0)) begin
			a  = 32'h100 + (($random(seed) & 15) << 3); // 16 words
			d  = {$random(seed), $random(seed)};
			ar = ($random(seed) & 3) != 0;
			dr = ($random(seed) & 3) != 0;
			dispatch_en         <= 1'b1;
			dispatch_addr       <= a;     // same address even when not ready
			dispatch_addr_ready <= ar;
			dispatch_data       <= dr ? d : ~d;
			dispatch_data_ready <= dr;
			p_tag.push_back(tail_out);
			p_addr.push_back(a);
			p_data.push_back(d);
			p_ar.push_back(ar);
			p_dr.push_back(dr);
			disp = 1'b1;
		end
		disp_last = disp;
		if ($random(seed) & 1) begin
			r = $random(seed) & 3;
			rd_en   <= 1'b1;
			addr_rd <= 32'h100 + (($random(seed) & 15) << 3);
			ld_pos  <= tail_out;
			if (disp && r == 0) begin
				addr_rd <= a;                // younger than the store dispatched now
				ld_pos  <= tail_out + 1'b1;
			end else if (r == 1 && p_tag.size() > 0) begin
				ld_pos <= p_tag[($random(seed) & 32'h7fff) % p_tag.size()]; // cuts the window
			end
		end
	endtask

	// retire and write back everything still queued
	task drain_queue();
		for (w = 0; w < 600 && !(p_tag.size() == 0 && chk_empty && !full); w++)
			drive_cycle(0, 2);
		if (!(p_tag.size() == 0 && chk_empty)) begin
			$display("timeout: the store queue did not drain to memory");
			$display("TEST FAILED");
			$finish;
		end
	endtask

	initial begin
		dispatch_en         = 1'b0;
		dispatch_addr       = '0;
		dispatch_addr_ready = 1'b0;
		dispatch_data       = '0;
		dispatch_data_ready = 1'b0;
		ex_en               = 1'b0;
		ex_index            = '0;
		ex_addr             = '0;
		ex_addr_en          = 1'b0;
		ex_data             = '0;
		ex_data_en          = 1'b0;
		rt_en               = 1'b0;
		rd_en               = 1'b0;
		addr_rd             = '0;
		ld_pos              = '0;
		disp_last           = 1'b0;
		tb_errors           = 0;
		for (w = 0; w < 20 && reset !== 1'b0; w++)
			@(posedge clock);
		if (reset !== 1'b0) begin
			$display("timeout: reset never released");
			$display("TEST FAILED");
			$finish;
		end
		repeat (4) drive_cycle(0, 0); // loads on a cleared memory
		repeat (24) drive_cycle(2, 0); // retire held, queue fills
		@(posedge clock);
		if (full !== 1'b1) begin
			$display("[ERROR] %0t: full low with retire held", $time);
			tb_errors = tb_errors + 1;
		end
		drain_queue();
		repeat (800) drive_cycle(1, 1); // mixed traffic
		drain_queue();
		repeat (4) drive_cycle(0, 0); // loads from memory only
		@(negedge clock); // last load compared here
		#10;
		$display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
		if (chk_errors == 0 && tb_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* tb_checker.sv */
`timescale 1ns/10ps

module tb_checker
	import lsq_pkg::*,
	mem_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    dispatch_en,
	input  addr_t   dispatch_addr,
	input  logic    dispatch_addr_ready,
	input  data_t   dispatch_data,
	input  logic    dispatch_data_ready,
	input  logic    ex_en,
	input  sq_idx_t ex_index,
	input  addr_t   ex_addr,
	input  logic    ex_addr_en,
	input  data_t   ex_data,
	input  logic    ex_data_en,
	input  logic    rt_en,
	input  logic    rd_en,
	input  addr_t   addr_rd,
	input  sq_idx_t ld_pos,
	input  sq_idx_t tail_out,
	input  logic    full,
	input  data_t   data_rd,
	input  logic    rd_valid,
	input  logic    fwd_hit,
	input  logic    pop,       // internal drain pulse of the DUT
	input  logic    mem_req,   // internal write port of the DUT
	input  addr_t   mem_addr,
	input  data_t   mem_wdata,
	output int      errors,
	output logic    empty      // shadow queue holds no store
);

	// shadow queue, indexed by tag like the hardware
	addr_t   sh_addr [SQ_SIZE];
	data_t   sh_data [SQ_SIZE];
	logic    sh_ar [SQ_SIZE];
	logic    sh_dr [SQ_SIZE];
	sq_idx_t sh_head, sh_tail;
	int      count;
	int      retired;          // queued stores already retired
	logic    req_q;            // mem_req one edge ago
	data_t   sh_mem [MEM_WORDS];

	// queue state after this cycle's inputs
	addr_t   nx_addr [SQ_SIZE];
	data_t   nx_data [SQ_SIZE];
	logic    nx_ar [SQ_SIZE];
	logic    nx_dr [SQ_SIZE];
	sq_idx_t nx_head, nx_tail;
	int      nx_count;

	assign empty = (count == 0);

	initial errors = 0;

	// pop first, execute fill-in next, dispatch last
	task automatic next_state();
		nx_addr  = sh_addr;
		nx_data  = sh_data;
		nx_ar    = sh_ar;
		nx_dr    = sh_dr;
		nx_head  = sh_head;
		nx_tail  = sh_tail;
		nx_count = count;
		if (pop && nx_count > 0) begin
			nx_head  = nx_head + 1'b1;
			nx_count = nx_count - 1;
		end
		if (ex_en && ex_addr_en) begin
			nx_addr[ex_index] = ex_addr;
			nx_ar[ex_index]   = 1'b1;
		end
		if (ex_en && ex_data_en) begin
			nx_data[ex_index] = ex_data;
			nx_dr[ex_index]   = 1'b1;
		end
		if (dispatch_en && nx_count < SQ_SIZE - 1) begin // one slot always stays free
			nx_addr[nx_tail] = dispatch_addr;
			nx_ar[nx_tail]   = dispatch_addr_ready;
			nx_data[nx_tail] = dispatch_data;
			nx_dr[nx_tail]   = dispatch_data_ready;
			nx_tail  = nx_tail + 1'b1;
			nx_count = nx_count + 1;
		end
	endtask

	// youngest ready store older than pos with the same address, else memory
	function automatic data_t expected_load(input addr_t a, input sq_idx_t pos,
			input sq_idx_t start, output logic hit);
		sq_idx_t n;
		sq_idx_t idx;
		n   = pos - start; // stores older than the load
		hit = 1'b0;
		for (int k = SQ_SIZE - 1; k >= 0; k--) begin
			idx = start + sq_idx_t'(k);
			if (k < int'(n) && nx_ar[idx] && nx_addr[idx] == a) begin
				hit = 1'b1;
				return nx_data[idx];
			end
		end
		return sh_mem[a[MEM_OFS_W +: MEM_IDX_W]];
	endfunction

	// combinational outputs are settled by the falling edge
	always @(negedge clock) begin
		data_t exp_d;
		logic  exp_h;
		if (!reset) begin
			if (full !== (count == SQ_SIZE - 1)) begin
				$display("[ERROR] %0t: full is %b with %0d stores queued", $time, full, count);
				errors = errors + 1;
			end
			if (tail_out !== sh_tail) begin
				$display("[ERROR] %0t: tail_out %0d expected %0d", $time, tail_out, sh_tail);
				errors = errors + 1;
			end
			if (rd_valid !== rd_en) begin
				$display("[ERROR] %0t: rd_valid does not follow rd_en", $time);
				errors = errors + 1;
			end
			if (rd_en) begin
				next_state(); // the load sees same-cycle writes
				exp_d = expected_load(addr_rd, ld_pos, nx_head, exp_h);
				if (data_rd !== exp_d || fwd_hit !== exp_h) begin
					$display("[ERROR] %0t: load %h ld_pos %0d got %h hit %b expected %h hit %b",
						$time, addr_rd, ld_pos, data_rd, fwd_hit, exp_d, exp_h);
					errors = errors + 1;
				end
			end
		end
	end

	always @(posedge clock) begin
		logic rt_step;
		if (reset) begin
			sh_head = '0;
			sh_tail = '0;
			count   <= 0;
			retired = 0;
			req_q   = 1'b0;
			for (int i = 0; i < SQ_SIZE; i++) begin
				sh_ar[i] = 1'b0;
				sh_dr[i] = 1'b0;
			end
			for (int i = 0; i < MEM_WORDS; i++)
				sh_mem[i] = '0;
		end else begin
			rt_step = rt_en && (retired < count); // retire stops at the youngest store
			// a new request must carry the oldest store
			if (mem_req && !req_q) begin
				if (count == 0 || !sh_ar[sh_head] || !sh_dr[sh_head]
						|| mem_addr !== sh_addr[sh_head] || mem_wdata !== sh_data[sh_head]) begin
					$display("[ERROR] %0t: write %h data %h does not match the oldest store",
						$time, mem_addr, mem_wdata);
					errors = errors + 1;
				end
				if (retired == 0) begin
					$display("[ERROR] %0t: write %h issued before its store retired",
						$time, mem_addr);
					errors = errors + 1;
				end
				sh_mem[mem_addr[MEM_OFS_W +: MEM_IDX_W]] = mem_wdata;
			end
			req_q = mem_req;
			if (pop && count == 0) begin
				$display("[ERROR] %0t: pop with no store queued", $time);
				errors = errors + 1;
			end
			next_state();
			sh_addr = nx_addr;
			sh_data = nx_data;
			sh_ar   = nx_ar;
			sh_dr   = nx_dr;
			sh_head = nx_head;
			sh_tail = nx_tail;
			count   <= nx_count;
			if (pop && retired > 0)
				retired = retired - 1;
			if (rt_step)
				retired = retired + 1;
		end
	end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clock,
	output logic reset
);

	// 100 ns period
	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clock);
		reset <= 1'b0; // released on the third rising edge
	end

endmodule

/* lsq_top.sv */
`timescale 1ns/10ps

module lsq_top
	import lsq_pkg::*,
	mem_pkg::*;
(
	input  logic    clock,
	input  logic    reset,

	input  logic    dispatch_en,
	input  addr_t   dispatch_addr,
	input  logic    dispatch_addr_ready,
	input  data_t   dispatch_data,
	input  logic    dispatch_data_ready,

	input  logic    ex_en,
	input  sq_idx_t ex_index,
	input  addr_t   ex_addr,
	input  logic    ex_addr_en,
	input  data_t   ex_data,
	input  logic    ex_data_en,

	input  logic    rt_en,

	input  logic    rd_en,
	input  addr_t   addr_rd,
	input  sq_idx_t ld_pos,

	output sq_idx_t tail_out,
	output logic    full,

	output data_t   data_rd,
	output logic    rd_valid,
	output logic    fwd_hit
);

	logic  head_valid, pop;
	addr_t head_addr, mem_addr, mem_rd_addr;
	data_t head_data, mem_wdata, fwd_data, mem_rd_data;
	logic  mem_req, mem_ack;

	store_queue u_store_queue (
		.clock (clock), .reset (reset),
		.dispatch_en (dispatch_en), .dispatch_addr (dispatch_addr),
		.dispatch_addr_ready (dispatch_addr_ready), .dispatch_data (dispatch_data),
		.dispatch_data_ready (dispatch_data_ready),
		.ex_en (ex_en), .ex_index (ex_index), .ex_addr (ex_addr),
		.ex_addr_en (ex_addr_en), .ex_data (ex_data), .ex_data_en (ex_data_en),
		.rt_en (rt_en),
		.rd_en (rd_en), .addr_rd (addr_rd), .ld_pos (ld_pos),
		.pop (pop),
		.tail_out (tail_out), .full (full),
		.head_valid (head_valid), .head_addr (head_addr), .head_data (head_data),
		.fwd_data (fwd_data), .fwd_hit (fwd_hit)
	);

	store_commit u_store_commit (
		.clock (clock), .reset (reset),
		.head_valid (head_valid), .head_addr (head_addr), .head_data (head_data),
		.pop (pop),
		.mem_req (mem_req), .mem_addr (mem_addr), .mem_wdata (mem_wdata),
		.mem_ack (mem_ack)
	);

	// memory sees the word address of the load
	assign mem_rd_addr = {addr_rd[ADDR_W-1:MEM_OFS_W], {MEM_OFS_W{1'b0}}};

	data_memory u_data_memory (
		.clock (clock), .reset (reset),
		.mem_req (mem_req), .mem_addr (mem_addr), .mem_wdata (mem_wdata),
		.mem_ack (mem_ack),
		.rd_addr (mem_rd_addr), .rd_data (mem_rd_data)
	);

	assign data_rd  = fwd_hit ? fwd_data : mem_rd_data; // queue wins over memory
	assign rd_valid = rd_en;                            // always answered same cycle

endmodule

/* data_memory.sv */
`timescale 1ns/10ps

module data_memory
	import lsq_pkg::*,
	mem_pkg::*;
(
	input  logic  clock,
	input  logic  reset,

	// write side of the four-phase handshake
	input  logic  mem_req,
	input  addr_t mem_addr,
	input  data_t mem_wdata,
	output logic  mem_ack,

	// load port, no latency
	input  addr_t rd_addr,
	output data_t rd_data
);

	data_t    mem [MEM_WORDS];
	mem_idx_t wr_idx;
	mem_idx_t rd_idx;

	// low bits are the byte offset and are ignored
	assign wr_idx  = mem_addr[MEM_OFS_W +: MEM_IDX_W];
	assign rd_idx  = rd_addr[MEM_OFS_W +: MEM_IDX_W];
	assign rd_data = mem[rd_idx];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= '0; // loads to untouched words read zero
			mem_ack <= 1'b0;
		end else if (mem_req && !mem_ack) begin
			// new request, write once and acknowledge
			mem[wr_idx] <= mem_wdata;
			mem_ack     <= 1'b1;
		end else if (!mem_req) begin
			mem_ack <= 1'b0; // phase four
		end
	end

endmodule

/* store_commit.sv */
`timescale 1ns/10ps

module store_commit
	import lsq_pkg::*,
	mem_pkg::*;
(
	input  logic  clock,
	input  logic  reset,

	input  logic  head_valid, // head is retired and its data is ready
	input  addr_t head_addr,
	input  data_t head_data,
	output logic  pop,        // one cycle, advances the queue head

	// four-phase write port
	output logic  mem_req,
	output addr_t mem_addr,
	output data_t mem_wdata,
	input  logic  mem_ack
);

	typedef enum logic [1:0] {
		S_IDLE, // wait for a committed head
		S_REQ,  // req high until ack rises
		S_REL,  // req low until ack falls
		S_POP   // retire the head from the queue
	} state_t;

	state_t state, state_next;

	addr_t lat_addr;
	data_t lat_data;

	assign mem_req   = (state == S_REQ);
	assign pop       = (state == S_POP);
	assign mem_addr  = {lat_addr[ADDR_W-1:MEM_OFS_W], {MEM_OFS_W{1'b0}}}; // word aligned
	assign mem_wdata = lat_data;

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE: if (head_valid) state_next = S_REQ;
			S_REQ:  if (mem_ack) state_next = S_REL;
			S_REL:  if (!mem_ack) state_next = S_POP;
			S_POP:  state_next = S_IDLE; // head moves at this edge
			default: state_next = S_IDLE;
		endcase
	end

	// hold the store stable for the whole handshake
	always_ff @(posedge clock) begin
		if (state == S_IDLE && head_valid) begin
			lat_addr <= head_addr;
			lat_data <= head_data;
		end
	end

	always_ff @(posedge clock) begin
		if (reset)
			state <= S_IDLE;
		else
			state <= state_next;
	end

endmodule

/* store_queue.sv */
`timescale 1ns/10ps

module store_queue
	import lsq_pkg::*;
(
	input  logic    clock,
	input  logic    reset,

	// dispatch, in program order
	input  logic    dispatch_en,
	input  addr_t   dispatch_addr,
	input  logic    dispatch_addr_ready, // 0 for an indirect store
	input  data_t   dispatch_data,
	input  logic    dispatch_data_ready,

	// execute fill-in by tag
	input  logic    ex_en,
	input  sq_idx_t ex_index,
	input  addr_t   ex_addr,
	input  logic    ex_addr_en,
	input  data_t   ex_data,
	input  logic    ex_data_en,

	input  logic    rt_en, // retire the next store

	// load lookup
	input  logic    rd_en,
	input  addr_t   addr_rd,
	input  sq_idx_t ld_pos,

	input  logic    pop, // head went to memory

	output sq_idx_t tail_out,
	output logic    full,

	// drain side
	output logic    head_valid,
	output addr_t   head_addr,
	output data_t   head_data,

	output data_t   fwd_data,
	output logic    fwd_hit
);

	addr_t             addr [SQ_SIZE];
	addr_t             addr_next [SQ_SIZE];
	data_t             data [SQ_SIZE];
	data_t             data_next [SQ_SIZE];
	logic [SQ_SIZE-1:0] addr_ready, addr_ready_next;
	logic [SQ_SIZE-1:0] data_ready, data_ready_next;

	sq_idx_t head, head_next; // oldest store
	sq_idx_t rt, rt_next;     // first store not yet retired
	sq_idx_t tail, tail_next; // next free slot

	logic [SQ_SIZE-1:0] match_vec;
	sq_idx_t            sel_idx;
	logic               sel_hit;

	assign tail_out   = tail;
	assign full       = (tail + 1'b1 == head);
	assign head_valid = (head != rt) && data_ready[head]; // committed and data known
	assign head_addr  = addr[head];
	assign head_data  = data[head];

	// next state: pop, then execute, then dispatch
	always_comb begin
		addr_next       = addr;
		data_next       = data;
		addr_ready_next = addr_ready;
		data_ready_next = data_ready;
		head_next       = head;
		rt_next         = rt;
		tail_next       = tail;

		if (pop) begin
			addr_ready_next[head_next] = 1'b0;
			data_ready_next[head_next] = 1'b0;
			head_next = head_next + 1'b1;
		end

		if (rt_en && (rt != tail)) // retire pointer stops at the tail
			rt_next = rt + 1'b1;

		if (ex_en) begin
			if (ex_addr_en) begin
				addr_next[ex_index]       = ex_addr;
				addr_ready_next[ex_index] = 1'b1;
			end
			if (ex_data_en) begin
				data_next[ex_index]       = ex_data;
				data_ready_next[ex_index] = 1'b1;
			end
		end

		// a dispatch into a full queue is dropped
		if (dispatch_en && (tail_next + 1'b1 != head_next)) begin
			addr_next[tail_next]       = dispatch_addr;
			addr_ready_next[tail_next] = dispatch_addr_ready;
			data_next[tail_next]       = dispatch_data;
			data_ready_next[tail_next] = dispatch_data_ready;
			tail_next = tail_next + 1'b1;
		end
	end

	// match on next state so same-cycle writes are visible to the load
	always_comb begin
		sq_idx_t off;
		sq_idx_t span;
		span = ld_pos - head_next;
		for (int i = 0; i < SQ_SIZE; i++) begin
			off = sq_idx_t'(i) - head_next; // age of slot i from head
			match_vec[i] = rd_en && (off < span) && addr_ready_next[i]
				&& (addr_next[i] == addr_rd);
		end
	end

	forward_select u_forward_select (
		.match_vec (match_vec),
		.head      (head_next),
		.ld_pos    (ld_pos),
		.sel_idx   (sel_idx),
		.sel_hit   (sel_hit)
	);

	assign fwd_data = data_next[sel_idx];
	assign fwd_hit  = sel_hit;

	// payload
	always_ff @(posedge clock) begin
		addr <= addr_next;
		data <= data_next;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			addr_ready <= '0;
			data_ready <= '0;
			head       <= '0;
			rt         <= '0;
			tail       <= '0;
		end else begin
			addr_ready <= addr_ready_next;
			data_ready <= data_ready_next;
			head       <= head_next;
			rt         <= rt_next;
			tail       <= tail_next;
		end
	end

endmodule

/* forward_select.sv */
`timescale 1ns/10ps

module forward_select
	import lsq_pkg::*;
(
	input  logic [SQ_SIZE-1:0] match_vec, // per-entry hit, already limited to the window
	input  sq_idx_t            head,      // oldest entry still in the queue
	input  sq_idx_t            ld_pos,    // tail when the load was dispatched
	output sq_idx_t            sel_idx,
	output logic               sel_hit
);

	sq_idx_t span; // number of stores older than the load
	sq_idx_t idx;

	assign span = ld_pos - head;

	// walk from the oldest slot toward ld_pos - 1 so that a later (younger)
	// hit overwrites an earlier one
	always_comb begin
		sel_idx = head;
		sel_hit = 1'b0;
		idx     = head;
		for (int k = SQ_SIZE - 1; k >= 0; k--) begin
			idx = ld_pos - sq_idx_t'(k + 1); // k = 0 is the youngest older store
			if ((sq_idx_t'(k) < span) && match_vec[idx]) begin
				sel_idx = idx;
				sel_hit = 1'b1;
			end
		end
	end

endmodule

/* mem_pkg.sv */
package mem_pkg;

	localparam int MEM_WORDS = 256;                // 64-bit words
	localparam int MEM_IDX_W = $clog2(MEM_WORDS);  // word index width

	// byte offset inside a word, dropped on every memory access
	// so the word index is address bits 10:3
	localparam int MEM_OFS_W = 3;

	typedef logic [MEM_IDX_W-1:0] mem_idx_t;

endpackage

/* lsq_pkg.sv */
package lsq_pkg;

	// store queue geometry
	localparam int SQ_SIZE  = 8;                 // entries, one is always left empty
	localparam int SQ_IDX_W = $clog2(SQ_SIZE);   // index and tag width

	// core datapath widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;

	// queue index, also the tag handed back on dispatch
	// pointer arithmetic relies on this wrapping at SQ_SIZE
	typedef logic [SQ_IDX_W-1:0] sq_idx_t;

	typedef logic [ADDR_W-1:0] addr_t; // byte address
	typedef logic [DATA_W-1:0] data_t; // one 64-bit word

endpackage
